//--- source/cache_pkg.sv
package cache_pkg;

	// Line geometry
	localparam int LINE_WORDS = 16;
	localparam int OFFSET_BITS = 6;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [LINE_WORDS*32-1:0] line_t;
	// Taken from address bits 5 to 2
	typedef logic [$clog2(LINE_WORDS)-1:0] word_sel_t;

	// Operation driven to the host memory controller
	typedef enum logic [1:0] {
		HOST_IDLE,
		HOST_READ,
		HOST_WRITE
	} host_op_e;

	// One CPU word access
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  wr;
	} cache_req_t;

	// Result of a tag lookup
	typedef struct packed {
		logic  hit;
		logic  valid;
		logic  dirty;
		addr_t victim_addr;
	} lookup_t;

	// Single cycle pulses into the counters
	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} perf_event_t;

endpackage

//--- source/cache_tag_array.sv
`timescale 1ns/100ps

module cache_tag_array
	import cache_pkg::*;
	#(
	parameter int INDEX_BITS = 8
	)
	(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [INDEX_BITS-1:0] index,
	input  addr_t                 addr,
	input  logic                  tag_wr,
	input  logic                  tag_wr_dirty,
	input  logic                  dirty_set,
	output lookup_t               lookup
	);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = $bits(addr_t) - INDEX_BITS - OFFSET_BITS;

	logic [TAG_BITS-1:0]   tag_mem [LINES];
	logic [LINES-1:0]      valid_bits;
	logic [LINES-1:0]      dirty_bits;

	logic [TAG_BITS-1:0]   tag_q;
	logic [TAG_BITS-1:0]   addr_tag_q;
	logic [INDEX_BITS-1:0] index_q;
	logic                  valid_q;
	logic                  dirty_q;

	// Valid bits are the only state cleared by reset
	always_ff @(posedge clk) begin
		if (rst)
			valid_bits <= '0;
		else if (tag_wr)
			valid_bits[index] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (tag_wr) begin
			tag_mem[index] <= addr[$bits(addr_t)-1 -: TAG_BITS];
			dirty_bits[index] <= tag_wr_dirty;
		end else if (dirty_set) begin
			dirty_bits[index] <= 1'b1;
		end
		tag_q <= tag_mem[index];
		valid_q <= valid_bits[index];
		dirty_q <= dirty_bits[index];
		addr_tag_q <= addr[$bits(addr_t)-1 -: TAG_BITS];
		index_q <= index;
	end

	always_comb begin
		lookup.hit = valid_q && (tag_q == addr_tag_q);
		lookup.valid = valid_q;
		lookup.dirty = dirty_q;
		// Resident line rebuilt from its tag and slot
		lookup.victim_addr = {tag_q, index_q, {OFFSET_BITS{1'b0}}};
	end

endmodule

//--- source/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array
	import cache_pkg::*;
	#(
	parameter int INDEX_BITS = 8
	)
	(
	input  logic                  clk,
	input  logic [INDEX_BITS-1:0] index,
	input  word_sel_t             word_sel,
	input  logic                  line_wr,
	input  line_t                 line_wdata,
	input  logic                  word_wr,
	input  word_t                 word_wdata,
	output word_t                 rd_word,
	output line_t                 rd_line
	);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int WORD_BITS = $bits(word_t);

	line_t     line_mem [LINES];
	word_sel_t sel_q;

	always_ff @(posedge clk) begin
		if (line_wr)
			line_mem[index] <= line_wdata;
		else if (word_wr)
			line_mem[index][word_sel*WORD_BITS +: WORD_BITS] <= word_wdata;
	end

	// Word picked from the synchronously read line
	always_ff @(posedge clk) begin
		rd_line <= line_mem[index];
		sel_q <= word_sel;
	end

	assign rd_word = rd_line[sel_q*WORD_BITS +: WORD_BITS];

	// Fill and CPU write come from different controller states
	one_write_kind: assert property (@(posedge clk)
		!(line_wr && word_wr))
		else $error("line_wr and word_wr high in the same cycle");

endmodule

//--- source/cache_perf_counters.sv
`timescale 1ns/100ps

module cache_perf_counters
	import cache_pkg::*;
	#(
	parameter int COUNT_BITS = 16
	)
	(
	input  logic                  clk,
	input  logic                  rst,
	input  perf_event_t           events,
	output logic [COUNT_BITS-1:0] hit_count,
	output logic [COUNT_BITS-1:0] miss_count,
	output logic [COUNT_BITS-1:0] wb_count
	);

	typedef logic [COUNT_BITS-1:0] count_t;

	// Increment that sticks at all ones
	function automatic count_t sat_inc(input count_t c, input logic ev);
		sat_inc = (ev && (c != '1)) ? c + 1'b1 : c;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_count <= '0;
			miss_count <= '0;
			wb_count <= '0;
		end else begin
			hit_count <= sat_inc(hit_count, events.hit);
			miss_count <= sat_inc(miss_count, events.miss);
			wb_count <= sat_inc(wb_count, events.writeback);
		end
	end

	hit_miss_excl: assert property (@(posedge clk) disable iff (rst)
		!(events.hit && events.miss))
		else $error("hit and miss pulsed together");

endmodule

//--- source/cache_ctrl_fsm.sv
`timescale 1ns/100ps

module cache_ctrl_fsm
	import cache_pkg::*;
	#(
	parameter int INDEX_BITS = 8
	)
	(
	input  logic                  clk,
	input  logic                  rst,
	// CPU request and response
	input  logic                  req_valid,
	input  cache_req_t            req,
	output logic                  req_ready,
	output logic                  resp_valid,
	output word_t                 resp_rdata,
	input  logic                  resp_ready,
	// Host memory controller
	output host_op_e              host_op,
	output addr_t                 host_addr,
	output line_t                 host_wdata,
	input  line_t                 host_rdata,
	input  logic                  host_done,
	input  logic                  host_rvalid,
	// Array read results
	input  lookup_t               lookup,
	input  word_t                 rd_word,
	input  line_t                 rd_line,
	// Array control
	output logic [INDEX_BITS-1:0] index,
	output logic                  tag_wr,
	output logic                  tag_wr_dirty,
	output logic                  line_wr,
	output line_t                 line_wdata,
	output logic                  word_wr,
	output word_sel_t             word_sel,
	output word_t                 word_wdata,
	output perf_event_t           events
	);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		INSTALL,
		RESPOND
	} state_t;

	state_t     state;
	cache_req_t req_q;
	line_t      line_q;
	logic       cmp_q;
	logic       retry_q;
	logic       req_open;
	logic       accept;
	logic       compare;
	logic       need_wb;

	function automatic addr_t line_base(input addr_t a);
		line_base = a & ~addr_t'((1 << OFFSET_BITS) - 1);
	endfunction

	assign accept = (state == IDLE) && req_valid && req_ready;
	// Array outputs are valid in the second lookup cycle
	assign compare = (state == LOOKUP) && cmp_q;
	assign need_wb = lookup.valid && lookup.dirty;

	assign index = req_q.addr[OFFSET_BITS +: INDEX_BITS];
	assign word_sel = req_q.addr[OFFSET_BITS-1:2];
	assign word_wdata = req_q.wdata;
	assign word_wr = compare && lookup.hit && req_q.wr;

	// A line from the host is installed clean
	assign tag_wr = (state == INSTALL);
	assign tag_wr_dirty = 1'b0;
	assign line_wr = (state == INSTALL);
	assign line_wdata = line_q;
	assign host_wdata = line_q;

	// Only the first lookup of an access is counted
	assign events.hit = compare && lookup.hit && !retry_q;
	assign events.miss = compare && !lookup.hit && !retry_q;
	assign events.writeback = (state == WRITEBACK) && host_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cmp_q <= 1'b0;
			retry_q <= 1'b0;
			req_ready <= 1'b0;
			resp_valid <= 1'b0;
			host_op <= HOST_IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						state <= LOOKUP;
						cmp_q <= 1'b0;
						retry_q <= 1'b0;
						req_ready <= 1'b0;
					end else begin
						req_ready <= 1'b1;
					end
				end
				LOOKUP: begin
					cmp_q <= ~cmp_q;
					if (cmp_q) begin
						if (lookup.hit) begin
							state <= RESPOND;
							resp_valid <= 1'b1;
						end else if (need_wb) begin
							state <= WRITEBACK;
							host_op <= HOST_WRITE;
						end else begin
							state <= FILL;
							host_op <= HOST_READ;
						end
					end
				end
				WRITEBACK: begin
					if (host_done) begin
						state <= FILL;
						host_op <= HOST_READ;
					end
				end
				FILL: begin
					if (host_rvalid) begin
						state <= INSTALL;
						host_op <= HOST_IDLE;
					end
				end
				INSTALL: begin
					state <= LOOKUP;
					retry_q <= 1'b1;
				end
				RESPOND: begin
					if (resp_ready) begin
						state <= IDLE;
						resp_valid <= 1'b0;
						req_ready <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request copy, host address and line buffer
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
			host_addr <= line_base(req.addr);
		end
		if (compare) begin
			resp_rdata <= req_q.wr ? req_q.wdata : rd_word;
			if (!lookup.hit && need_wb) begin
				host_addr <= lookup.victim_addr;
				line_q <= rd_line;
			end
		end
		// Back to the request line once the victim is out
		if ((state == WRITEBACK) && host_done)
			host_addr <= line_base(req_q.addr);
		if ((state == FILL) && host_rvalid)
			line_q <= host_rdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			req_open <= 1'b0;
		else if (accept)
			req_open <= 1'b1;
		else if (resp_valid && resp_ready)
			req_open <= 1'b0;
	end

	host_op_stable: assert property (@(posedge clk) disable iff (rst)
		(host_op != HOST_IDLE) && !host_done && !host_rvalid
		|=> $stable(host_op) && $stable(host_addr))
		else $error("host_op or host_addr changed before the host answered");

	resp_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(resp_valid) |-> req_open)
		else $error("resp_valid rose with no accepted request");

endmodule

//--- source/mem_system.sv
`timescale 1ns/100ps

module mem_system
	import cache_pkg::*;
	#(
	parameter int INDEX_BITS = 8,
	parameter int COUNT_BITS = 16
	)
	(
	input  logic                  clk,
	input  logic                  rst,
	// CPU port
	input  logic                  req_valid,
	input  cache_req_t            req,
	output logic                  req_ready,
	output logic                  resp_valid,
	output word_t                 resp_rdata,
	input  logic                  resp_ready,
	// Host memory controller port
	output host_op_e              host_op,
	output addr_t                 host_addr,
	output line_t                 host_wdata,
	input  line_t                 host_rdata,
	input  logic                  host_done,
	input  logic                  host_rvalid,
	// Performance counters
	output logic [COUNT_BITS-1:0] hit_count,
	output logic [COUNT_BITS-1:0] miss_count,
	output logic [COUNT_BITS-1:0] wb_count
	);

	logic [INDEX_BITS-1:0] index;
	logic                  tag_wr;
	logic                  tag_wr_dirty;
	logic                  line_wr;
	logic                  word_wr;
	line_t                 line_wdata;
	line_t                 rd_line;
	word_sel_t             word_sel;
	word_t                 word_wdata;
	word_t                 rd_word;
	lookup_t               lookup;
	perf_event_t           events;

	cache_ctrl_fsm #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
		.clk, .rst,
		.req_valid, .req, .req_ready,
		.resp_valid, .resp_rdata, .resp_ready,
		.host_op, .host_addr, .host_wdata, .host_rdata, .host_done, .host_rvalid,
		.lookup, .rd_word, .rd_line,
		.index, .tag_wr, .tag_wr_dirty, .line_wr, .line_wdata,
		.word_wr, .word_sel, .word_wdata,
		.events
	);

	// host_addr holds the request line address outside a writeback,
	// so it also serves as the compare and install address
	cache_tag_array #(.INDEX_BITS(INDEX_BITS)) u_tags (
		.clk, .rst, .index,
		.addr         (host_addr),
		.tag_wr, .tag_wr_dirty,
		.dirty_set    (word_wr),
		.lookup
	);

	cache_data_array #(.INDEX_BITS(INDEX_BITS)) u_data (
		.clk, .index, .word_sel,
		.line_wr, .line_wdata,
		.word_wr, .word_wdata,
		.rd_word, .rd_line
	);

	cache_perf_counters #(.COUNT_BITS(COUNT_BITS)) u_perf (
		.clk, .rst, .events,
		.hit_count, .miss_count, .wb_count
	);

endmodule

//--- bench/host_mem_model.sv
`timescale 1ns/100ps

module host_mem_model
	import cache_pkg::*;
	#(
	parameter int SEED = 1
	)
	(
	input  logic     clk,
	input  host_op_e host_op,
	input  addr_t    host_addr,
	input  line_t    host_wdata,
	output line_t    host_rdata,
	output logic     host_done,
	output logic     host_rvalid
	);

	// Words never written follow the fill rule
	word_t mem [addr_t];
	// Line addresses of completed writes in arrival order
	addr_t write_log [$];
	int    seed;

	function automatic word_t read_word(input addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'h5a5a0000;
	endfunction

	task automatic answer_write();
		for (int w = 0; w < LINE_WORDS; w++)
			mem[host_addr + 4 * w] = host_wdata[w*32 +: 32];
		write_log.push_back(host_addr);
		host_done = 1'b1;
	endtask

	task automatic answer_read();
		for (int w = 0; w < LINE_WORDS; w++)
			host_rdata[w*32 +: 32] = read_word(host_addr + 4 * w);
		host_rvalid = 1'b1;
	endtask

	// Outputs change on the falling edge and serve one request at a time
	initial begin
		int delay;
		seed = SEED;
		host_done = 1'b0;
		host_rvalid = 1'b0;
		host_rdata = '0;
		forever begin
			@(negedge clk);
			host_done = 1'b0;
			host_rvalid = 1'b0;
			if (host_op != HOST_IDLE) begin
				delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (delay) @(negedge clk);
				if (host_op == HOST_WRITE)
					answer_write();
				else
					answer_read();
			end
		end
	end

endmodule

//--- bench/mem_system_tb.sv
`timescale 1ns/100ps

module mem_system_tb
	import cache_pkg::*;
	();

	localparam int INDEX_BITS = 4;
	localparam int COUNT_BITS = 16;
	localparam int SEED = 32'h25a5747a;
	localparam int WAIT_LIMIT = 200;
	// A and B share a line and C has A's index with another tag
	localparam addr_t ADDR_A = 32'h0000_1048;
	localparam addr_t ADDR_B = 32'h0000_1064;
	localparam addr_t ADDR_C = 32'h0000_1448;
	localparam word_t WDATA = 32'hcafe_0001;

	logic                  clk;
	logic                  rst;
	logic                  req_valid;
	cache_req_t            req;
	logic                  req_ready;
	logic                  resp_valid;
	logic                  resp_ready;
	word_t                 resp_rdata;
	host_op_e              host_op;
	addr_t                 host_addr;
	line_t                 host_wdata;
	line_t                 host_rdata;
	logic                  host_done;
	logic                  host_rvalid;
	logic [COUNT_BITS-1:0] hit_count;
	logic [COUNT_BITS-1:0] miss_count;
	logic [COUNT_BITS-1:0] wb_count;

	// Expected results are set before each access
	word_t                 exp_rdata;
	logic                  exp_hit;
	logic [COUNT_BITS-1:0] exp_hits;
	logic [COUNT_BITS-1:0] exp_misses;
	logic [COUNT_BITS-1:0] exp_wbs;
	int                    exp_reads;
	int                    exp_writes;
	addr_t                 exp_fill_addr;
	addr_t                 exp_wb_addr;
	word_sel_t             exp_wb_sel;
	word_t                 exp_wb_word;
	int                    n_reads;
	int                    n_writes;
	int                    errors;
	int                    mark;
	int                    tests;
	int                    failed_tests;
	int                    seed;

	mem_system #(.INDEX_BITS(INDEX_BITS), .COUNT_BITS(COUNT_BITS)) dut (.*);

	host_mem_model #(.SEED(SEED)) memory (
		.clk, .host_op, .host_addr, .host_wdata,
		.host_rdata, .host_done, .host_rvalid
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			n_reads <= 0;
			n_writes <= 0;
		end else begin
			if (host_rvalid)
				n_reads <= n_reads + 1;
			if (host_done)
				n_writes <= n_writes + 1;
		end
	end

	function automatic word_t fill_value(input addr_t a);
		return a ^ 32'h5a5a0000;
	endfunction

	function automatic addr_t line_addr(input addr_t a);
		return {a[31:6], 6'b0};
	endfunction

	task automatic record_error(input string text);
		$display("%s", text);
		errors++;
	endtask

	task automatic abort_run(input string text);
		$display("Timeout at %0t: %s", $time, text);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != mark) begin
			failed_tests++;
			$display("%s: failed with %0d errors", name, errors - mark);
		end else begin
			$display("%s: ok", name);
		end
		mark = errors;
	endtask

	// Send one request and hold its response for stall cycles
	task automatic access(input addr_t a, input logic wr, input word_t wd,
			input word_t expect_word, input logic hit, input int stall);
		int n;
		exp_rdata = expect_word;
		exp_hit = hit;
		if (hit)
			exp_hits++;
		else
			exp_misses++;
		req = '{addr: a, wdata: wd, wr: wr};
		req_valid = 1'b1;
		n = 0;
		while (!req_ready) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("request was never accepted");
		end
		@(negedge clk);
		req_valid = 1'b0;
		n = 0;
		while (!resp_valid) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("no response for an accepted request");
		end
		repeat (stall) @(negedge clk);
		resp_ready = 1'b1;
		@(negedge clk);
		if (stall > 0)
			resp_ready = 1'b0;
	endtask

	reset_port_check: assert property (@(posedge clk)
		$fell(rst) |=> req_ready && !resp_valid && host_op == HOST_IDLE)
		else record_error($sformatf(
			"Error at %0t: req_ready/resp_valid/host_op expected 1/0/0, got %b/%b/%0d",
			$time, $sampled(req_ready), $sampled(resp_valid), $sampled(host_op)));

	reset_count_check: assert property (@(posedge clk)
		$fell(rst) |=> hit_count == 0 && miss_count == 0 && wb_count == 0)
		else record_error($sformatf(
			"Error at %0t: hit/miss/wb_count expected 0/0/0, got %0d/%0d/%0d",
			$time, $sampled(hit_count), $sampled(miss_count), $sampled(wb_count)));

	rdata_check: assert property (@(posedge clk) disable iff (rst)
		resp_valid && resp_ready |-> resp_rdata == exp_rdata)
		else record_error($sformatf("Error at %0t: resp_rdata expected %h, got %h",
			$time, $sampled(exp_rdata), $sampled(resp_rdata)));

	count_check: assert property (@(posedge clk) disable iff (rst)
		resp_valid && resp_ready |->
			hit_count == exp_hits && miss_count == exp_misses && wb_count == exp_wbs)
		else record_error($sformatf(
			"Error at %0t: hit/miss/wb_count expected %0d/%0d/%0d, got %0d/%0d/%0d",
			$time, $sampled(exp_hits), $sampled(exp_misses), $sampled(exp_wbs),
			$sampled(hit_count), $sampled(miss_count), $sampled(wb_count)));

	// Number of completed host reads and writes so far
	host_ops_check: assert property (@(posedge clk) disable iff (rst)
		resp_valid && resp_ready |-> n_reads == exp_reads && n_writes == exp_writes)
		else record_error($sformatf(
			"Error at %0t: host reads/writes expected %0d/%0d, got %0d/%0d",
			$time, $sampled(exp_reads), $sampled(exp_writes),
			$sampled(n_reads), $sampled(n_writes)));

	fill_addr_check: assert property (@(posedge clk) disable iff (rst)
		host_rvalid |-> host_addr == exp_fill_addr)
		else record_error($sformatf("Error at %0t: host_addr expected %h, got %h",
			$time, $sampled(exp_fill_addr), $sampled(host_addr)));

	wb_check: assert property (@(posedge clk) disable iff (rst)
		host_done |-> host_addr == exp_wb_addr
			&& host_wdata[exp_wb_sel*32 +: 32] == exp_wb_word)
		else record_error($sformatf(
			"Error at %0t: host_addr/host_wdata word expected %h/%h, got %h/%h",
			$time, $sampled(exp_wb_addr), $sampled(exp_wb_word), $sampled(host_addr),
			$sampled(host_wdata[exp_wb_sel*32 +: 32])));

	hit_latency_check: assert property (@(posedge clk) disable iff (rst)
		exp_hit && $rose(resp_valid) |-> $past(req_valid && req_ready, 3))
		else record_error("hit response did not rise two cycles after acceptance");

	hold_check: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && !req_ready)
		else record_error("response changed or req_ready rose while resp_ready was low");

	initial begin
		word_sel_t pick;
		addr_t     a;
		seed = SEED;
		errors = 0;
		mark = 0;
		tests = 0;
		failed_tests = 0;
		exp_rdata = '0;
		exp_hit = 1'b0;
		exp_hits = '0;
		exp_misses = '0;
		exp_wbs = '0;
		exp_reads = 0;
		exp_writes = 0;
		exp_fill_addr = '0;
		exp_wb_addr = '0;
		exp_wb_sel = '0;
		exp_wb_word = '0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b1;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		finish_test("reset state");

		exp_reads++;
		exp_fill_addr = line_addr(ADDR_A);
		access(ADDR_A, 1'b0, '0, fill_value(ADDR_A), 1'b0, 0);
		finish_test("cold read miss");

		access(ADDR_B, 1'b0, '0, fill_value(ADDR_B), 1'b1, 0);
		finish_test("read hit");

		access(ADDR_A, 1'b1, WDATA, WDATA, 1'b1, 0);
		access(ADDR_A, 1'b0, '0, WDATA, 1'b1, 0);
		finish_test("write hit");

		// Dirty line of A goes out before C comes in
		exp_reads++;
		exp_writes++;
		exp_wbs++;
		exp_wb_addr = line_addr(ADDR_A);
		exp_wb_sel = ADDR_A[5:2];
		exp_wb_word = WDATA;
		exp_fill_addr = line_addr(ADDR_C);
		access(ADDR_C, 1'b0, '0, fill_value(ADDR_C), 1'b0, 0);
		exp_reads++;
		exp_fill_addr = line_addr(ADDR_A);
		access(ADDR_A, 1'b0, '0, WDATA, 1'b0, 0);
		wb_log_check: assert (memory.write_log.size() == 1
				&& memory.write_log[0] == exp_wb_addr)
			else record_error("host write log does not hold the evicted line address");
		finish_test("dirty eviction");

		resp_ready = 1'b0;
		for (int i = 0; i < 4; i++) begin
			pick = word_sel_t'($random(seed));
			a = line_addr(ADDR_A) | {26'b0, pick, 2'b00};
			access(a, 1'b0, '0, (a == ADDR_A) ? WDATA : fill_value(a), 1'b1,
				1 + ($unsigned($random(seed)) % 6));
		end
		resp_ready = 1'b1;
		finish_test("back-pressure");

		$display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- mem_system.f
source/cache_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_perf_counters.sv
source/cache_ctrl_fsm.sv
source/mem_system.sv
bench/host_mem_model.sv
bench/mem_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module mem_system_tb \
	--Mdir obj_dir -o mem_system_sim \
	-f mem_system.f

./obj_dir/mem_system_sim | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
